//--- files.f
botPkg.sv
streamPkg.sv
botFifo.sv
permSelector.sv
botPermute.sv
botPermuter.sv
botPermuterTb.sv

//--- Bender.yml
package:
  name: bot_permuter

sources:
  - files:
      - botPkg.sv
      - streamPkg.sv
      - botFifo.sv
      - permSelector.sv
      - botPermute.sv
      - botPermuter.sv
  - target: test
    files:
      - botPermuterTb.sv

//--- botPermuterTb.sv
`timescale 1ns/1ps
`default_nettype none

module botPermuterTb
    import botPkg::*, streamPkg::*;
();

    localparam int depthLog2        = 5;
    localparam int almostFullMargin = 8;
    localparam int depth            = 2 ** depthLog2;
    localparam int numRandom        = 150;
    localparam int maxEntries       = 4 + numRandom + depth;
    localparam int watchdogCycles   = 40 * maxEntries + 1000;

    // per set, ordering perm sits at index 5-perm
    localparam logic [31:0] orderWords [4][6] = '{
        '{"dbca", "dbac", "dcba", "dcab", "dabc", "dacb"},
        '{"cbad", "cbda", "cabd", "cadb", "cdba", "cdab"},
        '{"bacd", "badc", "bcad", "bcda", "bdac", "bdca"},
        '{"abcd", "abdc", "acbd", "acdb", "adbc", "adcb"}
    };

    logic        clk;
    logic        rst;
    logic        write;
    fifoEntryT   entryIn;
    logic        almostFull;
    logic        slowDown;
    logic        permutedBotValid;
    botT         permutedBot;
    logic        batchDone;

    logic [15:0] lfsr;
    permOutT     expQ [$];
    permOutT     expFront;  // zero while nothing is expected
    logic        expEmpty;
    logic        filling;   // buffer known empty at start, selector stalled
    int          stored;
    logic        testEnd;
    int          errorCount;
    int          outCount;
    int          entryCount;

    botPermuter #(
        .depthLog2        (depthLog2),
        .almostFullMargin (almostFullMargin)
    ) botPermuter_inst (
        .clk              (clk),
        .rst              (rst),
        .write            (write),
        .entryIn          (entryIn),
        .almostFull       (almostFull),
        .slowDown         (slowDown),
        .permutedBotValid (permutedBotValid),
        .permutedBot      (permutedBot),
        .batchDone        (batchDone)
    );

    always #5 clk = ~clk;

    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // taps 16 14 13 11
    endfunction

    task automatic randomBits(input int n, output logic [127:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            v    = {v[126:0], lfsr[0]};
        end
    endtask

    // output bit k takes the variable named by letter k
    function automatic botT applyOrder(input botT bot, input logic [31:0] word);
        botT        res;
        logic [3:0] src;
        logic [7:0] letter;
        for (int i = 0; i < 16; i++) begin
            src = '0;
            for (int k = 0; k < 4; k++) begin
                letter = word[31 - 8*k -: 8];
                if (i[k]) begin
                    src[letter - 8'h61] = 1'b1;
                end
            end
            res[8*i +: 8] = bot[8*src +: 8];
        end
        return res;
    endfunction

    task automatic refreshFront();
        expEmpty = expQ.size() == 0;
        if (expEmpty) begin
            expFront = '0;
        end else begin
            expFront = expQ[0];
        end
    endtask

    // smallest perm first, then smallest set
    task automatic expectEntry(input fifoEntryT e);
        permOutT item;
        int      remaining;
        remaining = $countones(e.mask);
        for (int p = 0; p < 6; p++) begin
            for (int s = 0; s < 4; s++) begin
                if (e.mask[s*6 + p]) begin
                    remaining--;
                    item = '{valid: 1'b1, bot: applyOrder(e.bot, orderWords[s][5 - p]),
                             batchDone: e.last && remaining == 0};
                    expQ.push_back(item);
                end
            end
        end
        if (e.mask == '0 && e.last) begin
            expQ.push_back('{valid: 1'b0, bot: '0, batchDone: 1'b1});  // lone batchDone
        end
        refreshFront();
    endtask

    task automatic driveEntry(input fifoEntryT e);
        write   = 1'b1;
        entryIn = e;
        entryCount++;
        expectEntry(e);
    endtask

    task automatic makeEntry(output fifoEntryT e);
        logic [127:0] r;
        logic [127:0] m;
        logic [127:0] kind;
        randomBits(128, r);
        e.bot = r;
        randomBits(3, kind);
        case (kind[2:0])
            3'd0: e.mask = '0;
            3'd1, 3'd2: begin
                randomBits(24, m);
                randomBits(24, r);
                e.mask = m[23:0] & r[23:0];  // sparse
            end
            3'd7: e.mask = '1;
            default: begin
                randomBits(24, m);
                e.mask = m[23:0];
            end
        endcase
        randomBits(2, r);
        e.last = &r[1:0];
    endtask

    task automatic waitDrain();
        while (!expEmpty) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        #1;
    endtask

    task automatic randomPhase(input int count);
        fifoEntryT    e;
        logic [127:0] r;
        int           sent;
        int           stall;
        sent  = 0;
        stall = 0;
        while (sent < count) begin
            @(posedge clk);
            #1;
            write = 1'b0;
            if (stall > 0) begin
                stall--;
            end else begin
                randomBits(3, r);
                if (r[2:0] == 3'b111) begin
                    randomBits(3, r);
                    stall = int'(r[2:0]) + 3;  // bursts of 3 to 10 cycles
                end
            end
            slowDown = stall > 0;
            randomBits(1, r);
            if (r[0] && !almostFull) begin
                makeEntry(e);
                driveEntry(e);
                sent++;
            end
        end
        @(posedge clk);
        #1;
        write    = 1'b0;
        slowDown = 1'b0;
    endtask

    task automatic fillPhase();
        fifoEntryT e;
        slowDown = 1'b1;
        filling  = 1'b1;
        stored   = 0;
        while (!almostFull && stored < depth) begin
            makeEntry(e);
            driveEntry(e);
            stored++;
            @(posedge clk);
            #1;
        end
        write = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        filling  = 1'b0;
        slowDown = 1'b0;
    endtask

    task automatic printSummary(input logic timedOut);
        $display("summary: %0d entries written, %0d results seen, %0d errors",
                 entryCount, outCount, errorCount);
        if (errorCount == 0 && !timedOut) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
    endtask

    // results leave the expected queue in the order they appear
    always @(posedge clk) begin
        if (!rst && (permutedBotValid || batchDone)) begin
            if (permutedBotValid) begin
                outCount++;
            end
            if (!expEmpty) begin
                void'(expQ.pop_front());
            end
            refreshFront();
        end
    end

    resetQuiet: assert property (@(posedge clk)
        rst |=> !permutedBotValid && !batchDone && !almostFull)
        else begin
            errorCount++;
            $display("outputs were not cleared by reset");
        end

    flagsMatch: assert property (@(posedge clk) disable iff (rst)
        (permutedBotValid || batchDone) |->
            {permutedBotValid, batchDone} == {expFront.valid, expFront.batchDone})
        else begin
            errorCount++;
            $display("FAILED {permutedBotValid,batchDone}: got %h expected %h",
                     {$sampled(permutedBotValid), $sampled(batchDone)},
                     {$sampled(expFront.valid), $sampled(expFront.batchDone)});
        end

    botMatch: assert property (@(posedge clk) disable iff (rst)
        permutedBotValid |-> permutedBot == expFront.bot)
        else begin
            errorCount++;
            $display("FAILED permutedBot: got %h expected %h",
                     $sampled(permutedBot), $sampled(expFront.bot));
        end

    // selector freezes at once, the two permuter stages still drain
    stallQuiet: assert property (@(posedge clk) disable iff (rst)
        $past(slowDown, 3) |-> !permutedBotValid)
        else begin
            errorCount++;
            $display("result issued three cycles into a slowDown stall");
        end

    fullLag: assert property (@(posedge clk) disable iff (rst)
        filling && $past(filling, 2) |->
            almostFull == ($past(stored, 2) > depth - almostFullMargin))
        else begin
            errorCount++;
            $display("FAILED almostFull: got %h expected %h",
                     $sampled(almostFull), !$sampled(almostFull));
        end

    drained: assert property (@(posedge clk) testEnd |-> expEmpty && !almostFull)
        else begin
            errorCount++;
            $display("expected results missing or almostFull still high at the end");
        end

    initial begin
        fifoEntryT    e;
        logic [127:0] r;
        clk        = 1'b0;
        rst        = 1'b1;
        write      = 1'b0;
        entryIn    = '0;
        slowDown   = 1'b0;
        lfsr       = 16'd74;
        filling    = 1'b0;
        stored     = 0;
        testEnd    = 1'b0;
        errorCount = 0;
        outCount   = 0;
        entryCount = 0;
        refreshFront();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // all 24 orderings, then empty masks with and without the flag
        randomBits(128, r);
        e = '{bot: r, mask: '1, last: 1'b1};
        @(posedge clk);
        #1;
        driveEntry(e);
        e.mask = '0;
        @(posedge clk);
        #1;
        driveEntry(e);
        e.last = 1'b0;
        @(posedge clk);
        #1;
        driveEntry(e);
        makeEntry(e);
        e.last = 1'b1;
        @(posedge clk);
        #1;
        driveEntry(e);
        @(posedge clk);
        #1;
        write = 1'b0;
        waitDrain();

        randomPhase(numRandom);
        waitDrain();
        fillPhase();
        waitDrain();

        testEnd = 1'b1;
        @(posedge clk);
        #1;
        testEnd = 1'b0;
        @(posedge clk);
        printSummary(1'b0);
        $finish;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", watchdogCycles);
        printSummary(1'b1);
        $finish;
    end

endmodule

`default_nettype wire

//--- botPermuter.sv
`timescale 1ns/1ps
`default_nettype none

module botPermuter
    import botPkg::*, streamPkg::*;
#(
    parameter int depthLog2        = 9,
    parameter int almostFullMargin = 64
) (
    input  wire logic      clk,
    input  wire logic      rst,

    input  wire logic      write,
    input  wire fifoEntryT entryIn,
    output logic           almostFull,

    input  wire logic      slowDown,  // takes effect on the output 2 cycles later
    output logic           permutedBotValid,
    output botT            permutedBot,
    output logic           batchDone
);

    fifoEntryT head;
    logic      headValid;
    logic      pop;
    selectionT sel;
    permOutT   result;

    botFifo #(
        .depthLog2        (depthLog2),
        .almostFullMargin (almostFullMargin)
    ) botFifo_inst (
        .clk        (clk),
        .rst        (rst),
        .write      (write),
        .entryIn    (entryIn),
        .almostFull (almostFull),
        .pop        (pop),
        .head       (head),
        .headValid  (headValid)
    );

    permSelector permSelector_inst (
        .clk       (clk),
        .rst       (rst),
        .head      (head),
        .headValid (headValid),
        .pop       (pop),
        .slowDown  (slowDown),
        .sel       (sel)
    );

    botPermute botPermute_inst (
        .clk    (clk),
        .rst    (rst),
        .sel    (sel),
        .result (result)
    );

    assign permutedBotValid = result.valid;
    assign permutedBot      = result.bot;
    assign batchDone        = result.batchDone;

endmodule

`default_nettype wire

//--- botPermute.sv
`timescale 1ns/1ps
`default_nettype none

module botPermute
    import botPkg::*, streamPkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,

    input  wire selectionT sel,
    output permOutT        result
);

    // source variable for output bits 0 to 3, and pairs with output bit 0
    typedef struct packed {
        varPosT  a;
        varPosT  b;
        varPosT  c;
        varPosT  d;
        pairPosT ab;
        pairPosT ac;
        pairPosT ad;
    } posT;

    typedef struct packed {
        logic valid;
        posT  pos;
        botT  bot;
        logic batchDone;
    } stageT;

    stageT   stage;
    botByteT inBytes  [16];
    botByteT singles  [4];
    botByteT triples  [4];
    botByteT pairs    [6];
    botByteT pairsInv [6];  // complements of pairs in the same order
    botByteT outBytes [16];
    botT     permuted;

    // rows follow orderTable with letter positions a b c d then pair indices
    function automatic posT posLookup(input permSetT setIdx, input permIdxT permIdx);
        case ({setIdx, permIdx})
            5'o35: return '{2'd0, 2'd1, 2'd2, 2'd3, 3'd0, 3'd1, 3'd2};  // abcd
            5'o34: return '{2'd0, 2'd1, 2'd3, 2'd2, 3'd0, 3'd2, 3'd1};
            5'o33: return '{2'd0, 2'd2, 2'd1, 2'd3, 3'd1, 3'd0, 3'd2};
            5'o32: return '{2'd0, 2'd2, 2'd3, 2'd1, 3'd1, 3'd2, 3'd0};
            5'o31: return '{2'd0, 2'd3, 2'd1, 2'd2, 3'd2, 3'd0, 3'd1};
            5'o30: return '{2'd0, 2'd3, 2'd2, 2'd1, 3'd2, 3'd1, 3'd0};
            5'o25: return '{2'd1, 2'd0, 2'd2, 2'd3, 3'd0, 3'd3, 3'd4};  // bacd
            5'o24: return '{2'd1, 2'd0, 2'd3, 2'd2, 3'd0, 3'd4, 3'd3};
            5'o23: return '{2'd1, 2'd2, 2'd0, 2'd3, 3'd3, 3'd0, 3'd4};
            5'o22: return '{2'd1, 2'd2, 2'd3, 2'd0, 3'd3, 3'd4, 3'd0};
            5'o21: return '{2'd1, 2'd3, 2'd0, 2'd2, 3'd4, 3'd0, 3'd3};
            5'o20: return '{2'd1, 2'd3, 2'd2, 2'd0, 3'd4, 3'd3, 3'd0};
            5'o15: return '{2'd2, 2'd1, 2'd0, 2'd3, 3'd3, 3'd1, 3'd5};  // cbad
            5'o14: return '{2'd2, 2'd1, 2'd3, 2'd0, 3'd3, 3'd5, 3'd1};
            5'o13: return '{2'd2, 2'd0, 2'd1, 2'd3, 3'd1, 3'd3, 3'd5};
            5'o12: return '{2'd2, 2'd0, 2'd3, 2'd1, 3'd1, 3'd5, 3'd3};
            5'o11: return '{2'd2, 2'd3, 2'd1, 2'd0, 3'd5, 3'd3, 3'd1};
            5'o10: return '{2'd2, 2'd3, 2'd0, 2'd1, 3'd5, 3'd1, 3'd3};
            5'o05: return '{2'd3, 2'd1, 2'd2, 2'd0, 3'd4, 3'd5, 3'd2};  // dbca
            5'o04: return '{2'd3, 2'd1, 2'd0, 2'd2, 3'd4, 3'd2, 3'd5};
            5'o03: return '{2'd3, 2'd2, 2'd1, 2'd0, 3'd5, 3'd4, 3'd2};
            5'o02: return '{2'd3, 2'd2, 2'd0, 2'd1, 3'd5, 3'd2, 3'd4};
            5'o01: return '{2'd3, 2'd0, 2'd1, 2'd2, 3'd2, 3'd4, 3'd5};
            5'o00: return '{2'd3, 2'd0, 2'd2, 2'd1, 3'd2, 3'd5, 3'd4};
            default: return '1;  // unlisted codes give pair position 7
        endcase
    endfunction

    always_ff @(posedge clk) begin
        stage.pos <= posLookup(sel.set, sel.perm);
        stage.bot <= sel.bot;
        if (rst) begin
            stage.valid     <= 1'b0;
            stage.batchDone <= 1'b0;
        end else begin
            stage.valid     <= sel.valid;
            stage.batchDone <= sel.batchEnd;
        end
    end

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            inBytes[i] = stage.bot[8*i +: 8];
        end
        singles  = '{inBytes[4'b0001], inBytes[4'b0010], inBytes[4'b0100], inBytes[4'b1000]};
        triples  = '{inBytes[4'b1110], inBytes[4'b1101], inBytes[4'b1011], inBytes[4'b0111]};
        pairs    = '{inBytes[4'b0011], inBytes[4'b0101], inBytes[4'b1001],
                     inBytes[4'b0110], inBytes[4'b1010], inBytes[4'b1100]};
        pairsInv = '{inBytes[4'b1100], inBytes[4'b1010], inBytes[4'b0110],
                     inBytes[4'b1001], inBytes[4'b0101], inBytes[4'b0011]};
    end

    assign outBytes[4'b0000] = inBytes[4'b0000];
    assign outBytes[4'b1111] = inBytes[4'b1111];

    assign outBytes[4'b0001] = singles[stage.pos.a];
    assign outBytes[4'b0010] = singles[stage.pos.b];
    assign outBytes[4'b0100] = singles[stage.pos.c];
    assign outBytes[4'b1000] = singles[stage.pos.d];

    // three-variable bytes miss exactly one variable
    assign outBytes[4'b1110] = triples[stage.pos.a];
    assign outBytes[4'b1101] = triples[stage.pos.b];
    assign outBytes[4'b1011] = triples[stage.pos.c];
    assign outBytes[4'b0111] = triples[stage.pos.d];

    assign outBytes[4'b0011] = pairs[stage.pos.ab];
    assign outBytes[4'b0101] = pairs[stage.pos.ac];
    assign outBytes[4'b1001] = pairs[stage.pos.ad];
    assign outBytes[4'b0110] = pairsInv[stage.pos.ad];
    assign outBytes[4'b1010] = pairsInv[stage.pos.ac];
    assign outBytes[4'b1100] = pairsInv[stage.pos.ab];

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            permuted[8*i +: 8] = outBytes[i];
        end
    end

    always_ff @(posedge clk) begin
        result.bot <= permuted;
        if (rst) begin
            result.valid     <= 1'b0;
            result.batchDone <= 1'b0;
        end else begin
            result.valid     <= stage.valid;
            result.batchDone <= stage.batchDone;
        end
    end

    // a pair position of 6 or 7 would read past the 6-way mux
    pairInRange: assert property (@(posedge clk) disable iff (rst)
        stage.valid |-> stage.pos.ab < 3'd6 && stage.pos.ac < 3'd6 && stage.pos.ad < 3'd6)
        else $error("botPermute pair position out of range");

endmodule

`default_nettype wire

//--- permSelector.sv
`timescale 1ns/1ps
`default_nettype none

module permSelector
    import botPkg::*, streamPkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,

    input  wire fifoEntryT head,
    input  wire logic      headValid,
    output logic           pop,

    input  wire logic      slowDown,
    output selectionT      sel
);

    typedef enum logic {
        idle,
        busy
    } stateT;

    stateT    state;
    permMaskT workMask;
    botT      workBot;
    logic     workLast;

    logic [3:0] sections [permsPerSet];  // one bit per set for each perm
    logic       pending;
    permIdxT    pickPerm;
    permSetT    pickSet;
    logic [4:0] pickBit;
    permMaskT   restMask;
    logic       entryDone;
    logic       load;

    function automatic permSetT firstSet(input logic [3:0] section);
        casez (section)
            4'b???1: return 2'd0;
            4'b??10: return 2'd1;
            4'b?100: return 2'd2;
            default: return 2'd3;
        endcase
    endfunction

    always_comb begin
        for (int p = 0; p < permsPerSet; p++) begin
            for (int s = 0; s < 4; s++) begin
                sections[p][s] = workMask[s * permsPerSet + p];
            end
        end
    end

    // lowest perm wins, then lowest set inside it
    always_comb begin
        pending  = 1'b0;
        pickPerm = '0;
        pickSet  = '0;
        for (int p = permsPerSet - 1; p >= 0; p--) begin
            if (sections[p] != '0) begin
                pending  = 1'b1;
                pickPerm = permIdxT'(p);
                pickSet  = firstSet(sections[p]);
            end
        end
    end

    assign pickBit   = 5'(pickSet * permsPerSet + pickPerm);
    assign restMask  = workMask & ~(permMaskT'(1) << pickBit);
    assign entryDone = restMask == '0;  // also true for an empty mask

    // take the next entry when idle or in the cycle the current one finishes
    assign load = headValid && !slowDown && (state == idle || entryDone);
    assign pop  = load;

    always_ff @(posedge clk) begin
        if (!slowDown) begin
            sel.set  <= pickSet;
            sel.perm <= pickPerm;
            sel.bot  <= workBot;
        end

        if (load) begin
            workMask <= head.mask;
            workBot  <= head.bot;
            workLast <= head.last;
        end else if (!slowDown && state == busy) begin
            workMask <= restMask;
        end

        if (rst) begin
            state        <= idle;
            sel.valid    <= 1'b0;
            sel.batchEnd <= 1'b0;
        end else begin
            sel.valid    <= !slowDown && state == busy && pending;
            sel.batchEnd <= !slowDown && state == busy && entryDone && workLast;
            if (load) begin
                state <= busy;
            end else if (!slowDown && entryDone) begin
                state <= idle;
            end
        end
    end

endmodule

`default_nettype wire

//--- botFifo.sv
`timescale 1ns/1ps
`default_nettype none

module botFifo
    import streamPkg::*;
#(
    parameter int depthLog2        = 9,
    parameter int almostFullMargin = 64
) (
    input  wire logic      clk,
    input  wire logic      rst,

    input  wire logic      write,
    input  wire fifoEntryT entryIn,
    output logic           almostFull,

    input  wire logic      pop,
    output fifoEntryT      head,
    output logic           headValid
);

    localparam int depth = 2 ** depthLog2;

    // one extra bit tells full from empty
    typedef logic [depthLog2:0] ptrT;

    fifoEntryT mem [depth];

    ptrT  wrPtr;
    ptrT  rdPtr;
    ptrT  used;
    ptrT  free;
    logic full;
    logic empty;
    logic doWrite;
    logic doPop;

    assign used    = wrPtr - rdPtr;
    assign free    = ptrT'(depth) - used;
    assign full    = used == ptrT'(depth);
    assign empty   = used == '0;
    assign doWrite = write && !full;
    assign doPop   = pop && !empty;

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr[depthLog2-1:0]] <= entryIn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            almostFull <= 1'b0;
        end else begin
            if (doWrite) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            almostFull <= free < ptrT'(almostFullMargin);  // one cycle behind the count
        end
    end

    // show-ahead, the head is read straight from the array
    assign head      = mem[rdPtr[depthLog2-1:0]];
    assign headValid = !empty;

    // the writer has to hold off once almostFull is seen
    noOverflow: assert property (@(posedge clk) disable iff (rst) write |-> !full)
        else $error("botFifo written while full");

    // selector only pops an entry it was offered
    noUnderflow: assert property (@(posedge clk) disable iff (rst) pop |-> headValid)
        else $error("botFifo popped while empty");

endmodule

`default_nettype wire

//--- streamPkg.sv
`default_nettype none

package streamPkg;

    import botPkg::*;

    // one buffered bot with its wanted orderings
    typedef struct packed {
        botT      bot;
        permMaskT mask;
        logic     last;   // last entry of a batch
    } fifoEntryT;

    typedef struct packed {
        logic    valid;
        permSetT set;
        permIdxT perm;
        botT     bot;
        logic    batchEnd;  // may be set with valid low for an empty mask
    } selectionT;

    typedef struct packed {
        logic valid;
        botT  bot;
        logic batchDone;
    } permOutT;

endpackage

`default_nettype wire

//--- botPkg.sv
`default_nettype none

package botPkg;

    typedef logic [7:0]   botByteT;
    typedef logic [127:0] botT;       // byte i belongs to variable subset i, bit 0 is a
    typedef logic [23:0]  permMaskT;  // bit set*6+perm
    typedef logic [1:0]   permSetT;   // set 3 starts with a, set 0 with d
    typedef logic [2:0]   permIdxT;   // 0 to 5 within a set
    typedef logic [1:0]   varPosT;
    typedef logic [2:0]   pairPosT;   // ab ac ad bc bd cd

    // four ascii letters, position 0 in the top byte
    typedef logic [31:0] orderStrT;

    localparam int permsPerSet  = 6;
    localparam int numOrderings = 4 * permsPerSet;

    // letter at position k of an ordering moves to output bit k
    // mask bit n (= set*6+perm) selects entry 23-n of this list
    localparam orderStrT orderTable [numOrderings] = '{
        "abcd", "abdc", "acbd", "acdb", "adbc", "adcb",
        "bacd", "badc", "bcad", "bcda", "bdac", "bdca",
        "cbad", "cbda", "cabd", "cadb", "cdba", "cdab",
        "dbca", "dbac", "dcba", "dcab", "dabc", "dacb"
    };

endpackage

`default_nettype wire
